// ==== mif_ctrl.f ====
+incdir+hw
hw/mif_ctrl_pkg.sv
hw/dprio_map_pkg.sv
hw/rmw_if.sv
hw/mif_user_regs.sv
hw/mif_ctrl_fsm.sv
hw/mif_rmw_unit.sv
hw/mif_ctrl_top.sv
testbench/tb_mif_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MIF streamer control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_mif_ctrl -f mif_ctrl.f -o tb_mif_ctrl

out=$(./obj_dir/tb_mif_ctrl)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
else
  exit 1
fi

// ==== testbench/tb_mif_ctrl.sv ====
/*
 * Testbench for the MIF streamer control top with basic-block and MIF reader
 * models and directed register, raw, direct and stream tests
 */
`timescale 1ns/1ps
`include "mif_ctrl_consts.svh"

module tb_mif_ctrl
  import mif_ctrl_pkg::*, dprio_map_pkg::*;
();

  localparam int TIMEOUT = 200;  // cycles per wait

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        uif_go;
  logic [2:0]                  uif_mode;
  logic [1:0]                  uif_mif_mode;
  logic                        uif_busy;
  logic [`MIF_UIF_ADDR_W-1:0]  uif_addr;
  logic [`MIF_UIF_DATA_W-1:0]  uif_wdata;
  logic [`MIF_UIF_DATA_W-1:0]  uif_rdata;
  logic                        uif_addr_err;
  logic [`MIF_BASE_ADDR_W-1:0] mif_base_addr;
  logic                        mif_addr_mode;
  logic                        ctrl_av_go;
  logic                        ctrl_op_done;
  logic                        ctrl_op_err;
  logic [`MIF_AV_ADDR_W-1:0]   av_mif_addr;
  logic [`MIF_CTRL_DATA_W-1:0] av_mif_data;
  logic                        av_ctrl_req;
  logic                        av_opcode_err;
  logic                        av_done;
  logic                        ctrl_go;
  logic [2:0]                  ctrl_opcode;
  logic                        ctrl_lock;
  logic                        ctrl_wait;
  logic [`MIF_CTRL_ADDR_W-1:0] ctrl_addr;
  logic [`MIF_CTRL_DATA_W-1:0] ctrl_rdata;
  logic [`MIF_CTRL_DATA_W-1:0] ctrl_wdata;

  dprio_data_t bb_mem [0:255];   // basic-block model
  dprio_data_t exp_mem [0:255];  // expected contents
  bit [15:0]   rd_word;
  int          wait_cnt;
  logic        last_wr_lock;
  int          av_go_count;
  int          op_done_count;
  int          error_count;
  int          check_count;
  integer      seed;

  always #20 clk = ~clk;

  mif_ctrl_top i_dut (.*);

  function automatic dprio_data_t fill_word(input logic [7:0] a);
    return {a, ~a} ^ 16'h5A3C;
  endfunction

  // bits kept on a protected offset
  function automatic dprio_data_t protect_mask(input dprio_addr_t a);
    if (a == PMA_CGB_OFST)  return PMA_CGB_MASK;
    if (a == PMA_RREF_OFST) return PMA_RREF_MASK;
    if (a == PMA_DFE0_OFST) return PMA_DFE0_MASK;
    if (a == PMA_DCD_OFST)  return PMA_DCD_MASK;
    return '0;
  endfunction

  ////////////////////////////////////////
  // basic-block model and monitors
  ////////////////////////////////////////
  assign ctrl_wait  = ctrl_go | (wait_cnt != 0);  // rises with go
  assign ctrl_rdata = rd_word;

  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++)
        bb_mem[i] <= fill_word(i[7:0]);
      wait_cnt      <= 0;
      rd_word       <= '0;
      last_wr_lock  <= 1'b0;
      av_go_count   <= 0;
      op_done_count <= 0;
    end else begin
      if (ctrl_go) begin
        wait_cnt <= 3;
        if (ctrl_opcode == CTRL_OP_WR) begin
          bb_mem[ctrl_addr[7:0]] <= ctrl_wdata;
          last_wr_lock           <= ctrl_lock;
        end else begin
          rd_word <= bb_mem[ctrl_addr[7:0]];
        end
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end
      if (ctrl_av_go)
        av_go_count <= av_go_count + 1;
      if (ctrl_op_done)
        op_done_count <= op_done_count + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] seen,
                             input logic [31:0] expected);
    check_count++;
    if (seen !== expected) begin
      error_count++;
      $display("ERR t=%0t %s seen 0x%0h expected 0x%0h", $time, name, seen, expected);
    end
  endtask

  task automatic wait_busy_low(input string what);
    int n;
    n = 0;
    while (uif_busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (uif_busy) begin
      error_count++;
      $display("timeout: uif_busy did not fall after %s", what);
    end
  endtask

  // stream-mode register access with results one cycle after go
  task automatic reg_access(input logic [2:0] op, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic addr_err);
    @(negedge clk);
    uif_mif_mode <= MIF_STREAM;
    uif_mode     <= op;
    uif_addr     <= addr;
    uif_wdata    <= wdata;
    uif_go       <= 1'b1;
    @(negedge clk);
    uif_go   <= 1'b0;
    rdata    = uif_rdata;
    addr_err = uif_addr_err;
  endtask

  // direct or raw command that runs until busy falls
  task automatic user_cmd(input logic [1:0] mode, input logic [2:0] op,
                          input logic [11:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    uif_mif_mode <= mode;
    uif_mode     <= op;
    uif_addr     <= addr;
    uif_wdata    <= wdata;
    uif_go       <= 1'b1;
    @(negedge clk);
    uif_go <= 1'b0;
    wait_busy_low("user command");
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic reset_and_registers();
    logic [31:0] rd;
    logic        err;
    logic [31:0] base;
    check_value("uif_busy", 32'(uif_busy), 0);
    check_value("ctrl_go", 32'(ctrl_go), 0);
    check_value("ctrl_lock", 32'(ctrl_lock), 0);
    check_value("ctrl_av_go", 32'(ctrl_av_go), 0);
    check_value("ctrl_op_done", 32'(ctrl_op_done), 0);
    check_value("ctrl_op_err", 32'(ctrl_op_err), 0);
    check_value("uif_addr_err", 32'(uif_addr_err), 0);
    base = $random(seed);
    reg_access(UIF_OP_WR, REG_BASE_OFST, base, rd, err);
    check_value("mif_base_addr", mif_base_addr, base);
    reg_access(UIF_OP_RD, REG_BASE_OFST, 0, rd, err);
    check_value("uif_rdata", rd, base);
    reg_access(UIF_OP_WR, REG_CTRL_OFST, 32'h2, rd, err);  // addr_mode
    check_value("mif_addr_mode", 32'(mif_addr_mode), 1);
    reg_access(UIF_OP_RD, REG_CTRL_OFST, 0, rd, err);
    check_value("uif_rdata", rd, 32'h2);
    reg_access(UIF_OP_WR, REG_CTRL_OFST, 32'h0, rd, err);
    check_value("mif_addr_mode", 32'(mif_addr_mode), 0);
  endtask

  task automatic error_register();
    logic [31:0] rd;
    logic        err;
    reg_access(UIF_OP_RD, 12'd5, 0, rd, err);
    check_value("uif_addr_err", 32'(err), 1);
    @(negedge clk);
    check_value("uif_addr_err", 32'(uif_addr_err), 0);  // single cycle
    reg_access(UIF_OP_RD, REG_ERR_OFST, 0, rd, err);
    check_value("error register", rd, 1);
    check_value("ctrl_op_err", 32'(ctrl_op_err), 1);
    @(negedge clk);
    av_opcode_err <= 1'b1;
    @(negedge clk);
    av_opcode_err <= 1'b0;
    reg_access(UIF_OP_RD, REG_ERR_OFST, 0, rd, err);
    check_value("error register", rd, 3);
    reg_access(UIF_OP_WR, REG_CTRL_OFST, 32'h4, rd, err);  // clr_error
    @(negedge clk);
    check_value("ctrl_op_err", 32'(ctrl_op_err), 0);
    reg_access(UIF_OP_RD, REG_ERR_OFST, 0, rd, err);
    check_value("error register", rd, 0);
  endtask

  task automatic raw_mode_access();
    logic [31:0] r;
    logic [11:0] a;
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      a = (k == 0) ? PMA_RREF_OFST : {4'h0, r[23:16]};
      user_cmd(MIF_RAW_LOG, UIF_OP_WR, a, r);
      exp_mem[a[7:0]] = r[15:0];  // no masking in raw mode
      check_value("model word", 32'(bb_mem[a[7:0]]), 32'(exp_mem[a[7:0]]));
      user_cmd((k == 3) ? MIF_RAW_PHYS : MIF_RAW_LOG, UIF_OP_RD, a, 0);
      check_value("uif_rdata", uif_rdata, 32'(exp_mem[a[7:0]]));
    end
  endtask

  task automatic direct_mode_merge();
    logic [31:0] r;
    dprio_addr_t a;
    dprio_data_t m;
    dprio_addr_t ofst [4];
    ofst[0] = PMA_CGB_OFST;
    ofst[1] = PMA_RREF_OFST;
    ofst[2] = PMA_DFE0_OFST;
    ofst[3] = PMA_DCD_OFST;
    for (int k = 0; k < 5; k++) begin
      a = (k < 4) ? ofst[k] : 12'h040;  // last one unprotected
      r = $random(seed);
      m = protect_mask(a);
      exp_mem[a[7:0]] = (exp_mem[a[7:0]] & m) | (r[15:0] & ~m);
      user_cmd(MIF_DIRECT, UIF_OP_WR, a, r);
      check_value("model word", 32'(bb_mem[a[7:0]]), 32'(exp_mem[a[7:0]]));
      check_value("ctrl_lock at write", 32'(last_wr_lock), (k < 4) ? 1 : 0);
    end
  endtask

  task automatic stream_run();
    logic [31:0] rd;
    logic        err;
    logic [31:0] r;
    dprio_addr_t a;
    dprio_data_t m;
    int          n;
    int          go_before;
    int          done_before;
    dprio_addr_t req_addr [3];
    req_addr[0] = 12'h033;
    req_addr[1] = PMA_DFE0_OFST;
    req_addr[2] = 12'h07F;
    go_before = av_go_count;
    reg_access(UIF_OP_WR, REG_BASE_OFST, 32'h100, rd, err);
    reg_access(UIF_OP_WR, REG_CTRL_OFST, 32'h1, rd, err);  // strm_start
    @(negedge clk);
    check_value("ctrl_av_go", 32'(ctrl_av_go), 1);
    check_value("uif_busy", 32'(uif_busy), 1);
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      a = req_addr[k];
      m = protect_mask(a);
      exp_mem[a[7:0]] = (exp_mem[a[7:0]] & m) | (r[15:0] & ~m);
      done_before = op_done_count;
      @(negedge clk);
      av_mif_addr <= a[10:0];
      av_mif_data <= r[15:0];
      av_ctrl_req <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!ctrl_op_done && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!ctrl_op_done) begin
        error_count++;
        $display("timeout: no ctrl_op_done for MIF request %0d", k);
      end
      av_ctrl_req <= 1'b0;
      repeat (2) @(negedge clk);  // request stays low a while
      check_value("ctrl_op_done pulses", op_done_count - done_before, 1);
      check_value("model word", 32'(bb_mem[a[7:0]]), 32'(exp_mem[a[7:0]]));
    end
    check_value("uif_busy before av_done", 32'(uif_busy), 1);
    @(negedge clk);
    av_done <= 1'b1;
    @(negedge clk);
    av_done <= 1'b0;
    wait_busy_low("av_done");
    check_value("ctrl_av_go pulses", av_go_count - go_before, 1);
  endtask

  initial begin
    seed          = 3;
    error_count   = 0;
    check_count   = 0;
    reset         <= 1'b1;
    uif_go        <= 1'b0;
    uif_mode      <= UIF_OP_RD;
    uif_mif_mode  <= MIF_STREAM;
    uif_addr      <= '0;
    uif_wdata     <= '0;
    av_mif_addr   <= '0;
    av_mif_data   <= '0;
    av_ctrl_req   <= 1'b0;
    av_opcode_err <= 1'b0;
    av_done       <= 1'b0;
    for (int i = 0; i < 256; i++)
      exp_mem[i] = fill_word(i[7:0]);
    repeat (16) @(negedge clk);
    reset <= 1'b0;
    @(negedge clk);
    reset_and_registers();
    error_register();
    raw_mode_access();
    direct_mode_merge();
    stream_run();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== hw/mif_ctrl_top.sv ====
/*
 * MIF streamer control top: user registers, control FSM
 * and read-modify-write unit
 */
`timescale 1ns/1ps
`include "mif_ctrl_consts.svh"

module mif_ctrl_top
  import mif_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  // user register port
  input  logic                        uif_go,
  input  logic [2:0]                  uif_mode,
  input  logic [1:0]                  uif_mif_mode,
  output logic                        uif_busy,
  input  logic [`MIF_UIF_ADDR_W-1:0]  uif_addr,
  input  logic [`MIF_UIF_DATA_W-1:0]  uif_wdata,
  output logic [`MIF_UIF_DATA_W-1:0]  uif_rdata,
  output logic                        uif_addr_err,
  // MIF reader port
  output logic [`MIF_BASE_ADDR_W-1:0] mif_base_addr,
  output logic                        mif_addr_mode,
  output logic                        ctrl_av_go,
  output logic                        ctrl_op_done,
  output logic                        ctrl_op_err,
  input  logic [`MIF_AV_ADDR_W-1:0]   av_mif_addr,
  input  logic [`MIF_CTRL_DATA_W-1:0] av_mif_data,
  input  logic                        av_ctrl_req,
  input  logic                        av_opcode_err,
  input  logic                        av_done,
  // basic-block port
  output logic                        ctrl_go,
  output logic [2:0]                  ctrl_opcode,
  output logic                        ctrl_lock,
  input  logic                        ctrl_wait,
  output logic [`MIF_CTRL_ADDR_W-1:0] ctrl_addr,
  input  logic [`MIF_CTRL_DATA_W-1:0] ctrl_rdata,
  output logic [`MIF_CTRL_DATA_W-1:0] ctrl_wdata
);

  uif_op_e   uif_op;
  mif_mode_e mif_mode;
  logic      strm_start;
  logic      basic_rd_done;

  rmw_if rmw_bus ();

  assign uif_op   = uif_op_e'(uif_mode);
  assign mif_mode = mif_mode_e'(uif_mif_mode);

  mif_user_regs i_user_regs (
    .clk, .reset, .uif_go, .uif_mode(uif_op), .uif_mif_mode(mif_mode), .uif_addr,
    .uif_wdata, .ctrl_rdata, .basic_rd_done, .av_opcode_err, .uif_rdata, .uif_addr_err,
    .mif_base_addr, .mif_addr_mode, .strm_start, .ctrl_op_err
  );

  mif_ctrl_fsm i_ctrl_fsm (
    .clk, .reset, .uif_go, .uif_mode(uif_op), .uif_mif_mode(mif_mode), .strm_start,
    .ctrl_wait, .av_ctrl_req, .av_done, .uif_busy, .ctrl_go, .ctrl_opcode, .ctrl_lock,
    .ctrl_av_go, .ctrl_op_done, .basic_rd_done, .rmw(rmw_bus.fsm)
  );

  mif_rmw_unit i_rmw_unit (
    .clk, .reset, .uif_mif_mode(mif_mode), .uif_mode(uif_op), .uif_addr, .uif_wdata,
    .av_mif_addr, .av_mif_data, .ctrl_rdata, .ctrl_addr, .ctrl_wdata, .rmw(rmw_bus.rmw)
  );

endmodule

// ==== hw/mif_rmw_unit.sv ====
/*
 * Read-modify-write unit: basic-block address and write data,
 * protected-offset check and merge of saved read data
 */
`timescale 1ns/1ps
`include "mif_ctrl_consts.svh"

module mif_rmw_unit
  import mif_ctrl_pkg::*, dprio_map_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  mif_mode_e                  uif_mif_mode,
  input  uif_op_e                    uif_mode,
  input  logic [`MIF_UIF_ADDR_W-1:0] uif_addr,
  input  logic [`MIF_UIF_DATA_W-1:0] uif_wdata,
  input  logic [`MIF_AV_ADDR_W-1:0]  av_mif_addr,
  input  dprio_data_t                av_mif_data,
  input  dprio_data_t                ctrl_rdata,
  output dprio_addr_t                ctrl_addr,
  output dprio_data_t                ctrl_wdata,
  rmw_if.rmw                         rmw
);

  logic        strm_mode;
  logic        rmw_allowed;
  dprio_addr_t req_addr;
  dprio_data_t req_data;
  dprio_data_t saved_rdata;
  dprio_data_t mask;

  assign strm_mode = (uif_mif_mode == MIF_STREAM);

  // reader address is zero-extended, top bit is left clear
  assign req_addr = strm_mode ?
                    {{(`MIF_CTRL_ADDR_W-`MIF_AV_ADDR_W){1'b0}}, av_mif_addr} :
                    uif_addr[`MIF_CTRL_ADDR_W-1:0];
  assign req_data = strm_mode ? av_mif_data : uif_wdata[`MIF_CTRL_DATA_W-1:0];

  // raw mode writes every bit
  assign rmw_allowed = strm_mode | ((uif_mif_mode == MIF_DIRECT) & (uif_mode == UIF_OP_WR));

  assign mask = rmw_mask_of(ctrl_addr);

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      rmw.rmw_needed <= 1'b0;
    else if (rmw.merge_done)
      rmw.rmw_needed <= 1'b0;  // merged write goes out next
    else if (rmw.load_req)
      rmw.rmw_needed <= is_rmw_ofst(req_addr) & rmw_allowed;
  end

  ////////////////////////////////////////
  // address and data path
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rmw.load_req) begin
      ctrl_addr  <= req_addr;
      ctrl_wdata <= req_data;
    end else if (rmw.merge_done) begin
      ctrl_wdata <= (saved_rdata & mask) | (ctrl_wdata & ~mask);
    end
  end

  // old register contents for the merge
  always_ff @(posedge clk) begin
    if (rmw.rd_done)
      saved_rdata <= ctrl_rdata;
  end

endmodule

// ==== hw/mif_ctrl_fsm.sv ====
/*
 * MIF streamer main control FSM that runs user and MIF reader requests
 * as go/wait cycles on the basic block
 */
`timescale 1ns/1ps

module mif_ctrl_fsm
  import mif_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      uif_go,
  input  uif_op_e   uif_mode,
  input  mif_mode_e uif_mif_mode,
  input  logic      strm_start,
  input  logic      ctrl_wait,
  input  logic      av_ctrl_req,
  input  logic      av_done,
  output logic      uif_busy,
  output logic      ctrl_go,
  output ctrl_op_e  ctrl_opcode,
  output logic      ctrl_lock,
  output logic      ctrl_av_go,
  output logic      ctrl_op_done,
  output logic      basic_rd_done,
  rmw_if.fsm        rmw
);

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        user_mode;  // direct or raw
  logic        user_rd;
  logic        user_wr;
  logic        av_req_dly;
  logic        av_req_re;
  logic        av_accept;
  logic        av_src;     // request came from the MIF reader
  logic        access_end;

  assign user_mode  = (uif_mif_mode != MIF_STREAM);
  assign user_rd    = (state == ST_IDLE) & uif_go & user_mode & (uif_mode == UIF_OP_RD);
  assign user_wr    = (state == ST_IDLE) & uif_go & user_mode & (uif_mode == UIF_OP_WR);
  assign av_req_re  = av_ctrl_req & ~av_req_dly;
  assign av_accept  = (state == ST_WF_AV) & ~av_done & av_req_re;
  assign access_end = (state == ST_WF_B) & ~ctrl_wait;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (strm_start && !user_mode) next_state = ST_WF_AV;
        else if (user_rd)             next_state = ST_RD;
        else if (user_wr)             next_state = ST_CHK_ADDR;
      end
      ST_WF_AV: begin
        if (av_done)        next_state = ST_IDLE;
        else if (av_req_re) next_state = ST_CHK_ADDR;
      end
      ST_CHK_ADDR: next_state = rmw.rmw_needed ? ST_RD : ST_WR;  // protected offsets read first
      ST_WR, ST_RD: next_state = ST_WF_B;
      ST_WF_B: begin
        if (!ctrl_wait) begin
          if (rmw.rmw_needed) next_state = ST_RMW;
          else if (av_src)    next_state = ST_WF_AV;
          else                next_state = ST_IDLE;
        end
      end
      ST_RMW:  next_state = ST_WR;
      default: next_state = ST_IDLE;
    endcase
  end

  assign rmw.load_req   = user_rd | user_wr | av_accept;
  assign rmw.rd_done    = access_end & (ctrl_opcode == CTRL_OP_RD);
  assign rmw.merge_done = (state == ST_RMW);
  assign basic_rd_done  = rmw.rd_done;

  ////////////////////////////////////////
  // state and registered outputs
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= ST_IDLE;
      av_req_dly   <= 1'b0;
      av_src       <= 1'b0;
      uif_busy     <= 1'b0;
      ctrl_go      <= 1'b0;
      ctrl_opcode  <= CTRL_OP_RD;
      ctrl_lock    <= 1'b0;
      ctrl_av_go   <= 1'b0;
      ctrl_op_done <= 1'b0;
    end else begin
      state      <= next_state;
      av_req_dly <= av_ctrl_req;
      if (av_accept)              av_src <= 1'b1;
      else if (user_rd | user_wr) av_src <= 1'b0;
      uif_busy   <= (state != ST_IDLE) | (next_state != ST_IDLE);
      ctrl_go    <= (next_state == ST_WR) | (next_state == ST_RD);
      if (next_state == ST_WR)      ctrl_opcode <= CTRL_OP_WR;
      else if (next_state == ST_RD) ctrl_opcode <= CTRL_OP_RD;
      // held from the protected read through the merged write
      if ((state == ST_CHK_ADDR) && rmw.rmw_needed) ctrl_lock <= 1'b1;
      else if ((next_state == ST_IDLE) || (next_state == ST_WF_AV)) ctrl_lock <= 1'b0;
      ctrl_av_go   <= (state == ST_IDLE) & (next_state == ST_WF_AV);
      ctrl_op_done <= (state == ST_WF_B) & (next_state == ST_WF_AV);  // reader request served
    end
  end

endmodule

// ==== hw/mif_user_regs.sv ====
/*
 * MIF streamer user registers: base address, control strobes,
 * sticky error register and the user read-back mux
 */
`timescale 1ns/1ps
`include "mif_ctrl_consts.svh"

module mif_user_regs
  import mif_ctrl_pkg::*, dprio_map_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        uif_go,
  input  uif_op_e                     uif_mode,
  input  mif_mode_e                   uif_mif_mode,
  input  logic [`MIF_UIF_ADDR_W-1:0]  uif_addr,
  input  uif_word_u                   uif_wdata,
  input  dprio_data_t                 ctrl_rdata,
  input  logic                        basic_rd_done,
  input  logic                        av_opcode_err,
  output logic [`MIF_UIF_DATA_W-1:0]  uif_rdata,
  output logic                        uif_addr_err,
  output logic [`MIF_BASE_ADDR_W-1:0] mif_base_addr,
  output logic                        mif_addr_mode,
  output logic                        strm_start,
  output logic                        ctrl_op_err
);

  logic                 strm_go;
  logic                 reg_wr;
  logic                 reg_rd;
  logic                 addr_illegal;
  logic                 clr_error;
  logic [ERR_REG_W-1:0] err_reg;

  assign strm_go      = uif_go & (uif_mif_mode == MIF_STREAM);
  assign reg_wr       = strm_go & (uif_mode == UIF_OP_WR);
  assign reg_rd       = strm_go & (uif_mode == UIF_OP_RD);
  assign addr_illegal = strm_go & (uif_addr > REG_MAX_OFST);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mif_base_addr <= '0;
      mif_addr_mode <= 1'b0;
      strm_start    <= 1'b0;
      clr_error     <= 1'b0;
    end else begin
      strm_start <= 1'b0;  // strobes last one cycle
      clr_error  <= 1'b0;
      if (reg_wr && (uif_addr == REG_BASE_OFST))
        mif_base_addr <= uif_wdata.base_addr;
      if (reg_wr && (uif_addr == REG_CTRL_OFST)) begin
        strm_start    <= uif_wdata.ctrl.strm_start;
        mif_addr_mode <= uif_wdata.ctrl.addr_mode;
        clr_error     <= uif_wdata.ctrl.clr_error;
      end
    end
  end

  ////////////////////////////////////////
  // sticky errors
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_addr_err <= 1'b0;
      err_reg      <= '0;
    end else begin
      uif_addr_err <= addr_illegal;
      if (clr_error) begin
        err_reg <= '0;
      end else begin
        if (addr_illegal && !uif_addr_err)  // rising edge only
          err_reg[ERR_ADDR_BIT] <= 1'b1;
        if (av_opcode_err)
          err_reg[ERR_OPCODE_BIT] <= 1'b1;
      end
    end
  end

  assign ctrl_op_err = |err_reg;

  // read-back, stream regs or basic-block read data
  always_ff @(posedge clk) begin
    if (reg_rd) begin
      case (uif_addr)
        REG_BASE_OFST: uif_rdata <= mif_base_addr;
        REG_CTRL_OFST: uif_rdata <= {{(`MIF_UIF_DATA_W-2){1'b0}}, mif_addr_mode, 1'b0};
        REG_ERR_OFST:  uif_rdata <= {{(`MIF_UIF_DATA_W-ERR_REG_W){1'b0}}, err_reg};
        default:       uif_rdata <= '0;
      endcase
    end else if (basic_rd_done && (uif_mif_mode != MIF_STREAM) && (uif_mode == UIF_OP_RD)) begin
      uif_rdata <= {{(`MIF_UIF_DATA_W-`MIF_CTRL_DATA_W){1'b0}}, ctrl_rdata};
    end
  end

endmodule

// ==== hw/rmw_if.sv ====
/*
 * FSM to read-modify-write unit handshake
 */
`timescale 1ns/1ps

interface rmw_if;

  logic load_req;    // request accepted, latch address and data
  logic rd_done;     // basic-block read finished, rdata valid
  logic merge_done;  // rmw state, merge saved data into wdata
  logic rmw_needed;  // current offset is protected

  modport fsm (output load_req, output rd_done, output merge_done, input rmw_needed);

  modport rmw (input load_req, input rd_done, input merge_done, output rmw_needed);

endinterface

// ==== hw/dprio_map_pkg.sv ====
/*
 * Basic-block address map: address and data types and the
 * offsets that must be written by read-modify-write
 */
`include "mif_ctrl_consts.svh"

package dprio_map_pkg;

  typedef logic [`MIF_CTRL_ADDR_W-1:0] dprio_addr_t;
  typedef logic [`MIF_CTRL_DATA_W-1:0] dprio_data_t;

  // protected offsets, a mask bit of 1 keeps the old bit
  localparam dprio_addr_t PMA_CGB_OFST  = 'h0A;
  localparam dprio_addr_t PMA_RREF_OFST = 'h11;
  localparam dprio_addr_t PMA_DFE0_OFST = 'h1C;
  localparam dprio_addr_t PMA_DCD_OFST  = 'h2E;

  localparam dprio_data_t PMA_CGB_MASK  = 'h00C0;  // cgb enable and clock select
  localparam dprio_data_t PMA_RREF_MASK = 'h0300;  // rref select
  localparam dprio_data_t PMA_DFE0_MASK = 'hF000;
  localparam dprio_data_t PMA_DCD_MASK  = 'h000F;  // dcd control

  function automatic dprio_data_t rmw_mask_of(input dprio_addr_t ofst);
    case (ofst)
      PMA_CGB_OFST:  return PMA_CGB_MASK;
      PMA_RREF_OFST: return PMA_RREF_MASK;
      PMA_DFE0_OFST: return PMA_DFE0_MASK;
      PMA_DCD_OFST:  return PMA_DCD_MASK;
      default:       return '0;  // every bit writable
    endcase
  endfunction

  // every protected offset has a nonzero mask
  function automatic logic is_rmw_ofst(input dprio_addr_t ofst);
    return (rmw_mask_of(ofst) != '0);
  endfunction

endpackage

// ==== hw/mif_ctrl_pkg.sv ====
/*
 * MIF streamer control types: modes, opcodes, register map,
 * FSM states and the decoded user write word
 */
`include "mif_ctrl_consts.svh"

package mif_ctrl_pkg;

  typedef enum logic [1:0] {
    MIF_STREAM   = 2'd0,  // stream a MIF image from the reader
    MIF_DIRECT   = 2'd1,  // direct write, protected bits kept
    MIF_RAW_LOG  = 2'd2,
    MIF_RAW_PHYS = 2'd3   // same as raw logical here
  } mif_mode_e;

  typedef enum logic [2:0] {UIF_OP_RD = 3'd0, UIF_OP_WR = 3'd1} uif_op_e;
  typedef enum logic [2:0] {CTRL_OP_RD = 3'd0, CTRL_OP_WR = 3'd1} ctrl_op_e;

  // stream-mode register offsets
  localparam logic [`MIF_UIF_ADDR_W-1:0] REG_BASE_OFST = 'd0;
  localparam logic [`MIF_UIF_ADDR_W-1:0] REG_CTRL_OFST = 'd1;
  localparam logic [`MIF_UIF_ADDR_W-1:0] REG_ERR_OFST  = 'd2;
  localparam logic [`MIF_UIF_ADDR_W-1:0] REG_MAX_OFST  = 'd2;

  // sticky error bits
  localparam int ERR_ADDR_BIT   = 0;
  localparam int ERR_OPCODE_BIT = 1;
  localparam int ERR_REG_W      = 2;

  typedef enum logic [2:0] {
    ST_IDLE, ST_CHK_ADDR, ST_WR, ST_RD, ST_WF_B, ST_RMW, ST_WF_AV
  } ctrl_state_e;

  typedef struct packed {
    logic [`MIF_UIF_DATA_W-4:0] rsvd;
    logic                       clr_error;   // bit 2
    logic                       addr_mode;   // bit 1
    logic                       strm_start;  // bit 0
  } mif_ctrl_bits_t;

  // offset 0 takes the base address, offset 1 the control bits
  typedef union packed {
    logic [`MIF_BASE_ADDR_W-1:0] base_addr;
    mif_ctrl_bits_t              ctrl;
  } uif_word_u;

endpackage

// ==== hw/mif_ctrl_consts.svh ====
/*
 * MIF streamer control, port widths shared by the RTL and the testbench
 */
`ifndef MIF_CTRL_CONSTS_SVH
`define MIF_CTRL_CONSTS_SVH

// user register port
`define MIF_UIF_ADDR_W   12
`define MIF_UIF_DATA_W   32

// basic-block port
`define MIF_CTRL_ADDR_W  12
`define MIF_CTRL_DATA_W  16

// MIF reader port
`define MIF_AV_ADDR_W    11
`define MIF_BASE_ADDR_W  32

`endif
